/* f100l_params.svh */
`ifndef F100L_PARAMS_SVH
`define F100L_PARAMS_SVH

// Data and address width.
`define F100_WORD_W 16

// Only the low address bits reach the RAM.
`define F100_RAM_WORDS 1024

// First instruction fetched after reset.
`define F100_RESET_PC 16'h0040

// Word that test programs store their result into.
`define F100_RESULT_ADDR 16'h0080

`endif

/* f100l_pkg.sv */
`include "f100l_params.svh"

package f100l_pkg;

  typedef logic [`F100_WORD_W-1:0] word_t;

  // Upper nibble of the instruction word.
  typedef enum logic [3:0] {
    OP_SYS = 4'h0,
    OP_STO = 4'h4,
    OP_LDA = 4'h8,
    OP_ADD = 4'h9,
    OP_SUB = 4'ha,
    OP_CMP = 4'hb,
    OP_AND = 4'hc,
    OP_NEQ = 4'hd,
    OP_JMP = 4'hf
  } opcode_e;

  typedef enum logic [3:0] {
    ST_RESET,
    ST_FETCH_0,
    ST_FETCH_1,
    ST_DECODE,
    ST_OPND_0,
    ST_OPND_1,
    ST_EXECUTE,
    ST_WRITE_BACK,
    ST_STORE_1,
    ST_HALTED
  } state_e;

  typedef struct packed {
    logic m;
    logic c;
    logic s;
    logic v;
    logic z;
  } cr_t;

  typedef struct packed {
    logic  en;
    logic  we;
    word_t addr;
    word_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  we;
    word_t addr;
    word_t wdata;
  } host_cmd_t;

  typedef struct packed {
    logic  halted;
    logic  error;
    word_t pc;
    word_t accum;
    cr_t   flags;
  } cpu_status_t;

  typedef struct packed {
    logic [16:0] result;
    cr_t         flags;
  } alu_out_t;

endpackage

/* f100l_alu.sv */
module f100l_alu (
  input  f100l_pkg::opcode_e  op,
  input  f100l_pkg::word_t    accum,
  input  f100l_pkg::word_t    operand,
  input  f100l_pkg::cr_t      flags_in,
  output f100l_pkg::alu_out_t alu_out
);
  import f100l_pkg::*;

  logic [16:0] sum;
  logic [16:0] diff;
  logic [16:0] result;
  logic        add_v;
  logic        sub_v;
  cr_t         flags;

  // With M set the carry chains in from the previous word.
  assign sum = {1'b0, operand} + {1'b0, accum} + {16'd0, flags_in.m & flags_in.c};

  // Operand minus accumulator; bit 16 is the borrow.
  assign diff = flags_in.m
              ? {1'b0, operand} - {1'b0, accum} + {16'd0, flags_in.c} - 17'd1
              : {1'b0, operand} - {1'b0, accum};

  assign add_v = (operand[15] == accum[15]) && (sum[15] != accum[15]);
  assign sub_v = (operand[15] != accum[15]) && (diff[15] != operand[15]);

  always_comb
  begin
    case (op)
      OP_STO:         result = {1'b0, accum};
      OP_ADD:         result = sum;
      OP_SUB, OP_CMP: result = diff;
      OP_AND:         result = {1'b0, accum & operand};
      OP_NEQ:         result = {1'b0, accum ^ operand};
      default:        result = {1'b0, operand};
    endcase

    flags = flags_in;
    // A jump leaves the condition register alone
    if (op != OP_JMP)
    begin
      flags.c = result[16];
      flags.s = result[15];
      flags.z = (result[15:0] == 16'd0);
    end
    if (op == OP_ADD)
      flags.v = add_v;
    if (op == OP_SUB)
      flags.v = sub_v;
    if (op == OP_CMP)
      flags.m = 1'b1;
  end

  assign alu_out = {result, flags};

endmodule

/* f100l_control.sv */
`include "f100l_params.svh"

module f100l_control (
  input  logic                   raw_clk,
  input  logic                   button_reset,
  input  logic                   button_halt,
  output f100l_pkg::mem_req_t    mem_req,
  input  f100l_pkg::word_t       mem_rdata,
  output f100l_pkg::opcode_e     alu_op,
  output f100l_pkg::word_t       alu_accum,
  output f100l_pkg::word_t       alu_operand,
  output f100l_pkg::cr_t         alu_flags_in,
  input  f100l_pkg::alu_out_t    alu_out,
  output f100l_pkg::cpu_status_t status
);
  import f100l_pkg::*;

  state_e  state;
  word_t   pc;
  word_t   accum;
  cr_t     cr;
  word_t   ea;
  word_t   instr;
  word_t   opnd;
  word_t   result_q;
  logic    error_q;
  opcode_e instr_op;
  logic    is_literal;
  word_t   short_addr;

  assign instr_op   = opcode_e'(instr[15:12]);
  assign is_literal = (instr[10:0] == 11'd0);
  assign short_addr = {5'd0, instr[10:0]};

  // Bus is driven straight from the state; reads return one cycle later.
  always_comb
  begin
    mem_req.en    = (state == ST_FETCH_0) || (state == ST_OPND_0) || (state == ST_STORE_1);
    mem_req.we    = (state == ST_STORE_1);
    mem_req.addr  = (state == ST_FETCH_0) ? pc : ea;
    mem_req.wdata = result_q;
  end

  assign alu_op       = instr_op;
  assign alu_accum    = accum;
  assign alu_operand  = opnd;
  assign alu_flags_in = cr;

  always_comb
  begin
    status.halted = (state == ST_HALTED);
    status.error  = error_q;
    status.pc     = pc;
    status.accum  = accum;
    status.flags  = cr;
  end

  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
    begin
      state   <= ST_RESET;
      pc      <= `F100_RESET_PC;
      accum   <= '0;
      cr      <= '0;
      error_q <= 1'b0;
    end
    else if (!button_halt)
    begin
      state <= ST_HALTED;
    end
    else
    begin
      case (state)
        ST_RESET:
          state <= ST_FETCH_0;
        ST_FETCH_0:
        begin
          pc    <= pc + 16'd1;
          state <= ST_FETCH_1;
        end
        ST_FETCH_1:
        begin
          instr <= mem_rdata;
          state <= ST_DECODE;
        end
        ST_DECODE:
        begin
          case (instr_op)
            OP_SYS:
            begin
              // HALT is the only system instruction kept.
              error_q <= (instr[11:10] != 2'b01);
              state   <= ST_HALTED;
            end
            OP_STO, OP_LDA, OP_ADD, OP_SUB, OP_CMP, OP_AND, OP_NEQ, OP_JMP:
            begin
              if (instr[11])
              begin
                // Pointer and long-word forms are not supported.
                error_q <= 1'b1;
                state   <= ST_HALTED;
              end
              else
              begin
                if (is_literal)
                begin
                  ea <= pc;
                  pc <= pc + 16'd1;
                end
                else
                begin
                  ea   <= short_addr;
                  opnd <= short_addr;
                end
                if (instr_op == OP_STO || (instr_op == OP_JMP && !is_literal))
                  state <= ST_EXECUTE;
                else
                  state <= ST_OPND_0;
              end
            end
            default:
            begin
              error_q <= 1'b1;
              state   <= ST_HALTED;
            end
          endcase
        end
        ST_OPND_0:
          state <= ST_OPND_1;
        ST_OPND_1:
        begin
          opnd  <= mem_rdata;
          state <= ST_EXECUTE;
        end
        ST_EXECUTE:
        begin
          result_q <= alu_out.result[15:0];
          cr       <= alu_out.flags;
          state    <= ST_WRITE_BACK;
        end
        ST_WRITE_BACK:
        begin
          case (instr_op)
            OP_STO:
              state <= ST_STORE_1;
            OP_JMP:
            begin
              pc    <= result_q;
              state <= ST_FETCH_0;
            end
            OP_CMP:
              state <= ST_FETCH_0;
            default:
            begin
              accum <= result_q;
              state <= ST_FETCH_0;
            end
          endcase
        end
        ST_STORE_1:
          state <= ST_FETCH_0;
        ST_HALTED:
          state <= ST_HALTED;
        default:
          state <= ST_RESET;
      endcase
    end
  end

endmodule

/* f100l_ram.sv */
`include "f100l_params.svh"

module f100l_ram (
  input  logic                 raw_clk,
  input  logic                 button_reset,
  input  f100l_pkg::mem_req_t  mem_req,
  output f100l_pkg::word_t     mem_rdata,
  input  logic                 host_req,
  input  f100l_pkg::host_cmd_t host_cmd,
  output logic                 host_ack,
  output f100l_pkg::word_t     host_rdata
);
  import f100l_pkg::*;

  localparam int ADDR_W = $clog2(`F100_RAM_WORDS);

  word_t             mem [`F100_RAM_WORDS];
  logic [ADDR_W-1:0] core_addr;
  logic [ADDR_W-1:0] host_addr;
  logic              host_go;

  assign core_addr = mem_req.addr[ADDR_W-1:0];
  assign host_addr = host_cmd.addr[ADDR_W-1:0];

  // One host access per request, only in a cycle the core leaves free.
  assign host_go = host_req && !host_ack && !mem_req.en;

  always_ff @(posedge raw_clk)
  begin
    if (mem_req.en && mem_req.we)
      mem[core_addr] <= mem_req.wdata;
    else if (host_go && host_cmd.we)
      mem[host_addr] <= host_cmd.wdata;
  end

  // Core read port.
  always_ff @(posedge raw_clk)
  begin
    if (!button_reset)
      mem_rdata <= '0;
    else if (mem_req.en && !mem_req.we)
      mem_rdata <= mem[core_addr];
  end

  always_ff @(posedge raw_clk)
  begin
    if (host_go && !host_cmd.we)
      host_rdata <= mem[host_addr];
  end

  // Ack stays up until the host drops its request.
  always_ff @(posedge raw_clk)
  begin
    if (!host_req)
      host_ack <= 1'b0;
    else if (host_go)
      host_ack <= 1'b1;
  end

endmodule

/* f100l.sv */
module f100l (
  input  logic                   raw_clk,
  input  logic                   button_reset,
  input  logic                   button_halt,
  input  logic                   host_req,
  input  f100l_pkg::host_cmd_t   host_cmd,
  output logic                   host_ack,
  output f100l_pkg::word_t       host_rdata,
  output f100l_pkg::cpu_status_t status
);
  import f100l_pkg::*;

  mem_req_t mem_req;
  word_t    mem_rdata;
  opcode_e  alu_op;
  word_t    alu_accum;
  word_t    alu_operand;
  cr_t      alu_flags_in;
  alu_out_t alu_out;

  f100l_control f100l_control_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .mem_req      (mem_req),
    .mem_rdata    (mem_rdata),
    .alu_op       (alu_op),
    .alu_accum    (alu_accum),
    .alu_operand  (alu_operand),
    .alu_flags_in (alu_flags_in),
    .alu_out      (alu_out),
    .status       (status)
  );

  f100l_alu f100l_alu_i (
    .op       (alu_op),
    .accum    (alu_accum),
    .operand  (alu_operand),
    .flags_in (alu_flags_in),
    .alu_out  (alu_out)
  );

  f100l_ram f100l_ram_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .mem_req      (mem_req),
    .mem_rdata    (mem_rdata),
    .host_req     (host_req),
    .host_cmd     (host_cmd),
    .host_ack     (host_ack),
    .host_rdata   (host_rdata)
  );

endmodule

/* f100l_assert.sv */
module f100l_assert (
  input logic                   raw_clk,
  input logic                   button_reset,
  input logic                   host_req,
  input logic                   host_ack,
  input f100l_pkg::mem_req_t    mem_req,
  input f100l_pkg::cpu_status_t status
);

  int violation_count = 0;

  we_needs_en: assert property (@(posedge raw_clk) disable iff (!button_reset)
                                mem_req.we |-> mem_req.en)
  else
  begin
    $error("mem_req.we is high while mem_req.en is low");
    violation_count++;
  end

  // Ack only answers a pending request.
  ack_rise: assert property (@(posedge raw_clk) $rose(host_ack) |-> $past(host_req))
  else
  begin
    $error("host_ack rose without host_req");
    violation_count++;
  end

  ack_fall: assert property (@(posedge raw_clk) $fell(host_req) |-> ##[1:2] !host_ack)
  else
  begin
    $error("host_ack did not fall after host_req dropped");
    violation_count++;
  end

  halted_bus_idle: assert property (@(posedge raw_clk) disable iff (!button_reset)
                                    status.halted |-> !mem_req.en)
  else
  begin
    $error("mem_req.en is high while the core is halted");
    violation_count++;
  end

endmodule

bind f100l f100l_assert f100l_assert_i (
  .raw_clk      (raw_clk),
  .button_reset (button_reset),
  .host_req     (host_req),
  .host_ack     (host_ack),
  .mem_req      (mem_req),
  .status       (status)
);

/* f100l_tb.sv */
`include "f100l_params.svh"

module f100l_tb;
  import f100l_pkg::*;

  localparam word_t DATA_ADDR    = 16'h0090;
  localparam word_t RESULT_INIT  = 16'hdead;
  localparam int    ACK_TIMEOUT  = 20;
  localparam int    HALT_TIMEOUT = 500;

  // Program words and data words run from index 0 on the left.
  typedef struct packed {
    word_t [0:7] prog;
    word_t [0:1] data;
    word_t       accum;
    cr_t         flags;
    word_t       result;
    logic        error;
    word_t       pc;
    logic [3:0]  halt_delay;
  } test_row_t;

  logic        raw_clk;
  logic        button_reset;
  logic        button_halt;
  logic        host_req;
  host_cmd_t   host_cmd;
  logic        host_ack;
  word_t       host_rdata;
  cpu_status_t status;
  test_row_t   rows[$];

  f100l f100l_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .host_req     (host_req),
    .host_cmd     (host_cmd),
    .host_ack     (host_ack),
    .host_rdata   (host_rdata),
    .status       (status)
  );

  initial
  begin
    raw_clk = 1'b0;
    forever #2 raw_clk = ~raw_clk;
  end

  function automatic test_row_t make_row(input word_t [0:7] prog, input word_t [0:1] data,
                                         input word_t accum, input cr_t flags,
                                         input word_t result, input logic error,
                                         input word_t pc, input int halt_delay);
    test_row_t r;
    r.prog       = prog;
    r.data       = data;
    r.accum      = accum;
    r.flags      = flags;
    r.result     = result;
    r.error      = error;
    r.pc         = pc;
    r.halt_delay = halt_delay[3:0];
    return r;
  endfunction

  task automatic stop_on_failure();
    $display("*** FAILED ***");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_value(input int row_idx, input string name,
                             input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("[FAIL] row %0d %s: got %h, expected %h", row_idx, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (host_ack !== level && n < ACK_TIMEOUT)
    begin
      @(posedge raw_clk);
      #1;
      n++;
    end
    if (host_ack !== level)
    begin
      $display("Timed out waiting for host_ack to go to %0b.", level);
      stop_on_failure();
    end
  endtask

  // One four-phase host transfer, started and ended 1 unit after a clock edge.
  task automatic host_access(input logic we, input word_t addr, input word_t wdata,
                             output word_t rdata);
    host_cmd = '{we: we, addr: addr, wdata: wdata};
    host_req = 1'b1;
    wait_ack(1'b1);
    rdata    = host_rdata;
    host_req = 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic host_write(input word_t addr, input word_t wdata);
    word_t unused;
    host_access(1'b1, addr, wdata, unused);
  endtask

  task automatic wait_halted();
    int n;
    n = 0;
    while (status.halted !== 1'b1 && n < HALT_TIMEOUT)
    begin
      @(posedge raw_clk);
      #1;
      n++;
    end
    if (status.halted !== 1'b1)
    begin
      $display("Timed out waiting for the core to halt.");
      stop_on_failure();
    end
  endtask

  task automatic run_row(input int idx, input test_row_t row);
    word_t got;
    int    i;
    @(posedge raw_clk);
    #1;
    button_reset = 1'b0;
    button_halt  = 1'b1;
    repeat (2) @(posedge raw_clk);
    #1;
    for (i = 0; i < 8; i++)
      host_write(`F100_RESET_PC + word_t'(i), row.prog[i]);
    host_write(DATA_ADDR, row.data[0]);
    host_write(DATA_ADDR + 16'd1, row.data[1]);
    host_write(`F100_RESULT_ADDR, RESULT_INIT);
    button_reset = 1'b1;
    if (row.halt_delay != 0)
    begin
      repeat (row.halt_delay) @(posedge raw_clk);
      #1;
      button_halt = 1'b0;
    end
    wait_halted();
    check_value(idx, "status.accum", status.accum, row.accum);
    check_value(idx, "status.flags", status.flags, row.flags);
    check_value(idx, "status.error", status.error, row.error);
    // The stop point of a forced halt depends on timing.
    if (row.halt_delay == 0)
      check_value(idx, "status.pc", status.pc, row.pc);
    host_access(1'b0, `F100_RESULT_ADDR, 16'h0000, got);
    check_value(idx, "result word", got, row.result);
  endtask

  initial
  begin
    int idx;
    button_reset = 1'b0;
    button_halt  = 1'b1;
    host_req     = 1'b0;
    host_cmd     = '0;

    // Flags are m, c, s, v, z.
    rows.push_back(make_row({16'h8000, 16'h8001, 16'h4080, {5{16'h0400}}}, {2{16'h0000}},
                            16'h8001, 5'b00100, 16'h8001, 1'b0, 16'h0044, 0));
    rows.push_back(make_row({16'h8000, 16'h0000, 16'h4080, {5{16'h0400}}}, {2{16'h0000}},
                            16'h0000, 5'b00001, 16'h0000, 1'b0, 16'h0044, 0));
    rows.push_back(make_row({16'h8090, 16'h9091, 16'h4080, 16'h8090, 16'h9091, {3{16'h0400}}},
                            {16'h7fff, 16'h0001},
                            16'h8000, 5'b00110, 16'h8000, 1'b0, 16'h0046, 0));
    rows.push_back(make_row({16'h8090, 16'h9091, 16'h4080, 16'h8090, 16'h9091, {3{16'h0400}}},
                            {16'hffff, 16'h0002},
                            16'h0001, 5'b01000, 16'h0001, 1'b0, 16'h0046, 0));
    // Operand 0 minus accumulator 1.
    rows.push_back(make_row({16'h8090, 16'ha091, 16'h4080, 16'h8090, 16'ha091, {3{16'h0400}}},
                            {16'h0001, 16'h0000},
                            16'hffff, 5'b01100, 16'hffff, 1'b0, 16'h0046, 0));
    rows.push_back(make_row({16'h8090, 16'hb091, {6{16'h0400}}}, {16'h0005, 16'h0003},
                            16'h0005, 5'b11100, RESULT_INIT, 1'b0, 16'h0043, 0));
    // ADD after CMP takes the carry: 3 + 5 + 1.
    rows.push_back(make_row({16'h8090, 16'hb091, 16'h9091, 16'h4080, {4{16'h0400}}},
                            {16'h0005, 16'h0003},
                            16'h0009, 5'b10000, 16'h0009, 1'b0, 16'h0045, 0));
    rows.push_back(make_row({16'h8090, 16'h9090, 16'hc091, 16'h4080, {4{16'h0400}}},
                            {16'hf0f0, 16'hff0f},
                            16'he100, 5'b00100, 16'he100, 1'b0, 16'h0045, 0));
    rows.push_back(make_row({16'h8090, 16'h9090, 16'hd000, 16'h00ff, 16'h4080, {3{16'h0400}}},
                            {16'hf0f0, 16'h0000},
                            16'he11f, 5'b00100, 16'he11f, 1'b0, 16'h0046, 0));
    rows.push_back(make_row({16'h8000, 16'h1111, 16'hf045, 16'h8000, 16'h2222, 16'h4080,
                             {2{16'h0400}}}, {2{16'h0000}},
                            16'h1111, 5'b00000, 16'h1111, 1'b0, 16'h0047, 0));
    rows.push_back(make_row({16'h8000, 16'h5555, 16'h4080, 16'hf000, 16'h0047, 16'h8000,
                             16'h6666, 16'h0400}, {2{16'h0000}},
                            16'h5555, 5'b00000, 16'h5555, 1'b0, 16'h0048, 0));
    rows.push_back(make_row({16'h8000, 16'h00aa, 16'h3000, 16'h4080, {4{16'h0400}}},
                            {2{16'h0000}},
                            16'h00aa, 5'b00000, RESULT_INIT, 1'b1, 16'h0043, 0));
    rows.push_back(make_row({16'h8000, 16'h7777, 16'h4080, {5{16'h0400}}}, {2{16'h0000}},
                            16'h0000, 5'b00000, RESULT_INIT, 1'b0, 16'h0000, 2));

    for (idx = 0; idx < rows.size(); idx++)
      run_row(idx, rows[idx]);

    if (f100l_i.f100l_assert_i.violation_count == 0)
    begin
      $display("*** PASSED ***");
      $finish;
    end
    else
    begin
      $display("Bound assertions reported %0d violations.",
               f100l_i.f100l_assert_i.violation_count);
      stop_on_failure();
    end
  end

endmodule

/* src.f */
+incdir+.
f100l_pkg.sv
f100l_alu.sv
f100l_control.sv
f100l_ram.sv
f100l.sv
f100l_assert.sv
f100l_tb.sv

/* Bender.yml */
package:
  name: f100l

export_include_dirs:
  - .

sources:
  - files:
      - f100l_pkg.sv
      - f100l_alu.sv
      - f100l_control.sv
      - f100l_ram.sv
      - f100l.sv
  - target: test
    files:
      - f100l_assert.sv
      - f100l_tb.sv
